// ==== sources.f ====
+incdir+source
source/float_pkg.sv
source/fma_ctrl_pkg.sv
source/fma_length_cfg.sv
source/fma_operand_capture.sv
source/fma_sequencer.sv
source/fma_datapath.sv
source/fma_cell.sv
tb/fma_clock_gen.sv
tb/tb_fma_cell.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cell testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_fma_cell -o sim_tb_fma_cell

out=$(./obj_dir/sim_tb_fma_cell)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
    exit 0
else
    exit 1
fi

// ==== tb/tb_fma_cell.sv ====
/* Operands are small integers, so every dot product is exact in single precision.
   Neighbor requests are only raised while the cell reports not busy */
`timescale 1ns/1ps
`include "fma_params.svh"

module tb_fma_cell;

    localparam int SEED           = 29;
    localparam int TOTAL_PRODUCTS = 23;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_PRODUCTS + 200;

    logic clk, rst;
    logic up_req, left_req, right_busy, down_busy, cfg_we;
    logic [31:0] up_operand, left_operand;
    logic [`FMA_CNT_W-1:0] cfg_length;
    logic right_req, down_req, busy, answer_ready, error;
    logic [31:0] right_operand, down_operand, answer;

    // Reference model state
    int group_sum, group_count, group_len;
    logic [31:0] exp_answer, fwd_up, fwd_left;
    int answers_expected, answers_seen, errors_expected, errors_seen;
    int err_answer, err_fwd, err_busy, err_error, other_errors;
    int cycle_count, tests_passed, tests_failed, errors_before;

    fma_clock_gen clock_gen_inst (.clk, .rst);

    fma_cell fma_cell_inst (
        .clk, .rst, .up_req, .left_req, .up_operand, .left_operand,
        .right_busy, .down_busy, .cfg_we, .cfg_length,
        .right_req, .down_req, .right_operand, .down_operand,
        .busy, .answer, .answer_ready, .error
    );

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    a_answer : assert property (@(posedge clk) disable iff (rst)
        answer_ready |-> (answer == exp_answer) && (answers_seen < answers_expected)
    ) else begin
        err_answer++;
        $display("FAIL answer: got %h expected %h", answer, exp_answer);
    end

    // Pulse lands 5 cycles after the pair edge
    a_latency : assert property (@(posedge clk) disable iff (rst)
        answer_ready |-> $past(busy, 5) && !$past(busy, 6)
    ) else begin
        err_answer++;
        $display("answer_ready did not come 5 cycles after the pair edge");
    end

    a_forward : assert property (@(posedge clk) disable iff (rst)
        (right_req || down_req) |-> right_req && down_req &&
            (right_operand == fwd_left) && (down_operand == fwd_up)
    ) else begin
        err_fwd++;
        $display("FAIL right_operand/down_operand: got %h/%h expected %h/%h",
                 right_operand, down_operand, fwd_left, fwd_up);
    end

    // Each finished product goes on to both neighbors
    a_forward_req : assert property (@(posedge clk) disable iff (rst)
        ($fell(busy) && !error) |-> right_req && down_req
    ) else begin
        err_fwd++;
        $display("forward requests were not raised when the product finished");
    end

    // Busy spans the whole product and ends only with both neighbors free
    a_busy_span : assert property (@(posedge clk) disable iff (rst)
        ($fell(busy) && !error) |-> $past(busy, 5) && !$past(right_busy) && !$past(down_busy)
    ) else begin
        err_busy++;
        $display("busy fell early or while a neighbor was busy");
    end

    a_error : assert property (@(posedge clk) disable iff (rst)
        error |-> (answer == 32'hFFFF_FFFF) && (errors_seen < errors_expected)
    ) else begin
        err_error++;
        $display("FAIL answer: got %h expected ffffffff, or error not expected", answer);
    end

    always @(posedge clk) begin
        if (answer_ready) answers_seen <= answers_seen + 1;
        if (error) errors_seen <= errors_seen + 1;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the cell stopped responding", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Model and stimulus helpers
    // ----------------------------------------------------------
    function automatic logic [31:0] int_to_float(input int v);
        logic [31:0] mag;
        logic [31:0] shifted;
        logic [31:0] res;
        int          msb;
        mag = (v < 0) ? -v : v;
        res = '0;
        msb = 0;
        if (mag != 0) begin
            for (int i = 0; i < 32; i++) if (mag[i]) msb = i;
            shifted    = mag << (23 - msb);
            res[31]    = (v < 0);
            res[30:23] = 8'(msb + 127);
            res[22:0]  = shifted[22:0];   // Hidden bit dropped
        end
        return res;
    endfunction

    function automatic int small_int(input bit allow_zero);
        int v;
        v = int'($urandom_range(16)) - 8;
        while (!allow_zero && v == 0) v = int'($urandom_range(16)) - 8;
        return v;
    endfunction

    function automatic int total_errors();
        return err_answer + err_fwd + err_busy + err_error + other_errors;
    endfunction

    task automatic send_one(input bit left_side, input logic [31:0] val);
        @(posedge clk);
        while (busy) @(posedge clk);
        if (left_side) begin
            left_req     <= 1'b1;
            left_operand <= val;
        end else begin
            up_req     <= 1'b1;
            up_operand <= val;
        end
        @(posedge clk);   // Taken on this edge
        up_req   <= 1'b0;
        left_req <= 1'b0;
    endtask

    // Mode 0 sends both together, 1 up first, 2 left first
    task automatic send_pair(input logic [31:0] a, input logic [31:0] b, input int mode);
        int gap;
        gap = int'($urandom_range(3));
        if (mode == 0) begin
            @(posedge clk);
            while (busy) @(posedge clk);
            up_req       <= 1'b1;
            left_req     <= 1'b1;
            up_operand   <= a;
            left_operand <= b;
            @(posedge clk);
            up_req   <= 1'b0;
            left_req <= 1'b0;
        end else begin
            send_one(mode == 2, (mode == 2) ? b : a);
            repeat (gap) @(posedge clk);
            send_one(mode == 1, (mode == 2) ? a : b);
        end
    endtask

    task automatic do_product(input int a, input int b, input int mode);
        send_pair(int_to_float(a), int_to_float(b), mode);
        fwd_up   = int_to_float(a);
        fwd_left = int_to_float(b);
        group_sum += a * b;
        group_count++;
        if (group_count == group_len) begin
            exp_answer = int_to_float(group_sum);
            answers_expected++;
            group_sum   = 0;
            group_count = 0;
        end
    endtask

    task automatic expect_error();
        errors_expected++;
        group_sum   = 0;   // Partial sum is thrown away
        group_count = 0;
    endtask

    task automatic wait_idle();
        @(posedge clk);
        while (busy || answers_seen != answers_expected || errors_seen != errors_expected)
            @(posedge clk);
    endtask

    task automatic report(input string name);
        wait_idle();
        if (total_errors() == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, total_errors() - errors_before);
        end
        errors_before = total_errors();
    endtask

    // ----------------------------------------------------------
    // Tests
    // ----------------------------------------------------------
    initial begin
        int n;
        int sel;
        up_req = 1'b0;
        left_req = 1'b0;
        up_operand = '0;
        left_operand = '0;
        right_busy = 1'b0;
        down_busy = 1'b0;
        cfg_we = 1'b0;
        cfg_length = '0;
        group_sum = 0;
        group_count = 0;
        group_len = `FMA_DEFAULT_LEN;
        exp_answer = '0;
        fwd_up = '0;
        fwd_left = '0;
        answers_expected = 0;
        answers_seen = 0;
        errors_expected = 0;
        errors_seen = 0;
        err_answer = 0;
        err_fwd = 0;
        err_busy = 0;
        err_error = 0;
        other_errors = 0;
        cycle_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        errors_before = 0;
        void'($urandom(SEED));

        @(negedge rst);
        @(posedge clk);
        if (busy || right_req || down_req || answer_ready || error || answer != '0) begin
            other_errors++;
            $display("outputs were not quiet after reset");
        end

        for (int i = 0; i < 4; i++) do_product(small_int(0), small_int(0), 0);
        report("1 default length");

        @(posedge clk);
        cfg_we     <= 1'b1;
        cfg_length <= 8'd3;
        @(posedge clk);
        cfg_we    <= 1'b0;
        group_len = 3;
        // Third product always has a zero operand
        for (int i = 0; i < 6; i++) do_product((i == 2) ? 0 : small_int(1), small_int(0), 0);
        report("2 length three");

        for (int i = 0; i < 3; i++) do_product(small_int(0), small_int(0), 1 + (i % 2));
        report("3 single arrivals");

        for (int i = 0; i < 3; i++) begin
            n   = 5 + int'($urandom_range(10));
            sel = int'($urandom_range(2));
            @(posedge clk);
            right_busy <= (sel != 1);
            down_busy  <= (sel != 0);
            do_product(small_int(0), small_int(0), 0);
            repeat (n) @(posedge clk);
            right_busy <= 1'b0;
            down_busy  <= 1'b0;
        end
        report("4 neighbor busy");

        do_product(small_int(0), small_int(0), 0);
        send_pair(int_to_float(2), 32'h7F80_0000, 0);        // Infinity
        expect_error();
        wait_idle();
        do_product(small_int(0), small_int(0), 0);
        send_pair(int_to_float(3), 32'h0000_0001, 1);        // Denormal second
        expect_error();
        wait_idle();
        send_one(1'b0, 32'h7FC0_0000);                       // NaN alone
        expect_error();
        wait_idle();
        for (int i = 0; i < 3; i++) do_product(small_int(0), small_int(0), 0);
        report("5 input errors");

        $display("tests passed %0d, failed %0d, failed checks %0d",
                 tests_passed, tests_failed, total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb/fma_clock_gen.sv ====
/* Free-running 20 ns clock. Reset is held high for the first 8 rising edges */
`timescale 1ns/1ps

module fma_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;   // Released on the eighth edge
    end

endmodule

// ==== source/fma_cell.sv ====
/* One multiply-accumulate cell of a systolic array. Neighbors must not
   raise a request while busy is high */
`timescale 1ns/1ps
`include "fma_params.svh"

module fma_cell
    import float_pkg::*, fma_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  up_req,
    input  logic                  left_req,
    input  float_sp               up_operand,
    input  float_sp               left_operand,
    input  logic                  right_busy,
    input  logic                  down_busy,
    input  logic                  cfg_we,
    input  logic [`FMA_CNT_W-1:0] cfg_length,
    output logic                  right_req,
    output logic                  down_req,
    output float_sp               right_operand,
    output float_sp               down_operand,
    output logic                  busy,
    output float_sp               answer,
    output logic                  answer_ready,
    output logic                  error
);

    logic [`FMA_CNT_W-1:0] dot_length;
    logic                  both_valid;
    logic                  one_valid;
    logic                  in_error;
    logic                  capture_en;
    logic                  forward_en;
    logic                  last_product;
    dp_op_e                dp_op;
    float_sp               op_a;
    float_sp               op_b;

    // ----------------------------------------------------------
    // Configuration and operand capture
    // ----------------------------------------------------------
    fma_length_cfg length_cfg_inst (
        .clk, .rst, .cfg_we, .cfg_length, .dot_length
    );

    fma_operand_capture capture_inst (
        .clk, .rst, .up_req, .left_req, .up_operand, .left_operand,
        .capture_en, .forward_en, .op_a, .op_b,
        .both_valid, .one_valid, .in_error,
        .right_req, .down_req, .right_operand, .down_operand
    );

    // ----------------------------------------------------------
    // Control and arithmetic
    // ----------------------------------------------------------
    fma_sequencer sequencer_inst (
        .clk, .rst, .both_valid, .one_valid, .in_error,
        .right_busy, .down_busy, .dot_length,
        .capture_en, .forward_en, .busy, .answer_ready, .error,
        .dp_op, .last_product
    );

    fma_datapath datapath_inst (
        .clk, .rst, .dp_op, .last_product, .op_a, .op_b, .answer
    );

endmodule

// ==== source/fma_datapath.sv ====
/* Exponents are kept unbiased inside; mantissas are truncated, never rounded.
   Exponent overflow and underflow are not detected */
`timescale 1ns/1ps
`include "fma_params.svh"

module fma_datapath
    import float_pkg::*, fma_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  dp_op_e  dp_op,
    input  logic    last_product,
    input  float_sp op_a,
    input  float_sp op_b,
    output float_sp answer
);

    localparam int EXP_W    = `FMA_EXP_W;
    localparam int LEAD_BIT = ACC_MAN_W - 2;        // Weight-one position
    localparam int SHIFT_W  = $clog2(ACC_MAN_W);
    localparam logic [`FMA_FLOAT_W-1:0] ALL_ONES = '1;

    acc_float                    prod_q;
    acc_float                    acc_q;
    logic                        op_zero;
    logic signed [ACC_EXP_W-1:0] exp_sum;
    logic [ACC_MAN_W-1:0]        man_prod;
    acc_float                    prod_eff;
    acc_float                    prod_aln;
    acc_float                    acc_aln;
    logic signed [ACC_EXP_W:0]   exp_diff;
    logic [ACC_MAN_W-1:0]        mag_sum;
    logic                        sum_sign;
    logic [SHIFT_W-1:0]          lead_shift;
    acc_float                    acc_nrm;
    float_sp                     packed_ans;

    // ----------------------------------------------------------
    // Multiply
    // ----------------------------------------------------------
    assign op_zero  = (op_a.exponent == '0) || (op_b.exponent == '0);
    assign exp_sum  = ACC_EXP_W'(op_a.exponent) + ACC_EXP_W'(op_b.exponent)
                    - ACC_EXP_W'(2 * `FMA_EXP_BIAS);
    assign man_prod = ACC_MAN_W'({1'b1, op_a.mantissa}) * ACC_MAN_W'({1'b1, op_b.mantissa});

    // ----------------------------------------------------------
    // Align to the larger exponent
    // ----------------------------------------------------------
    always_comb begin
        prod_eff = prod_q;
        if (prod_q.mantissa[ACC_MAN_W-1]) begin   // Product in [2,4)
            prod_eff.exponent = prod_q.exponent + ACC_EXP_W'(1);
            prod_eff.mantissa = prod_q.mantissa >> 1;
        end
        acc_aln  = acc_q;
        prod_aln = prod_eff;
        exp_diff = prod_eff.exponent - acc_q.exponent;
        if (prod_eff.mantissa == '0) begin
            prod_aln.exponent = acc_q.exponent;       // Zero product, sum untouched
        end else if (acc_q.mantissa == '0) begin
            acc_aln.exponent = prod_eff.exponent;     // Exact zero takes any exponent
        end else if (exp_diff > 0) begin
            acc_aln.exponent = prod_eff.exponent;
            acc_aln.mantissa = acc_q.mantissa >> exp_diff;
        end else begin
            prod_aln.exponent = acc_q.exponent;
            prod_aln.mantissa = prod_eff.mantissa >> (-exp_diff);
        end
    end

    // Signed magnitude add, larger magnitude sets the sign
    always_comb begin
        if (acc_q.sign == prod_q.sign) begin
            mag_sum  = acc_q.mantissa + prod_q.mantissa;
            sum_sign = acc_q.sign;
        end else if (prod_q.mantissa >= acc_q.mantissa) begin
            mag_sum  = prod_q.mantissa - acc_q.mantissa;
            sum_sign = prod_q.sign;
        end else begin
            mag_sum  = acc_q.mantissa - prod_q.mantissa;
            sum_sign = acc_q.sign;
        end
    end

    // Carry goes right by one, cancellation goes left to the leading one
    always_comb begin
        lead_shift = '0;
        for (int i = 0; i < LEAD_BIT; i++) begin
            if (acc_q.mantissa[i]) lead_shift = SHIFT_W'(LEAD_BIT - i);
        end
        acc_nrm = acc_q;
        if (acc_q.mantissa[ACC_MAN_W-1]) begin
            acc_nrm.exponent = acc_q.exponent + ACC_EXP_W'(1);
            acc_nrm.mantissa = acc_q.mantissa >> 1;
        end else if (!acc_q.mantissa[LEAD_BIT]) begin
            acc_nrm.exponent = acc_q.exponent - ACC_EXP_W'(lead_shift);
            acc_nrm.mantissa = acc_q.mantissa << lead_shift;
        end
    end

    always_comb begin
        packed_ans.sign     = acc_q.sign;
        packed_ans.exponent = EXP_W'(acc_q.exponent + ACC_EXP_W'(`FMA_EXP_BIAS));
        packed_ans.mantissa = acc_q.mantissa[LEAD_BIT-1 -: `FMA_MAN_W];
        if (acc_q.mantissa == '0) packed_ans = '0;
    end

    // ----------------------------------------------------------
    // Registers
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (dp_op == MUL) begin
            prod_q.sign     <= op_a.sign ^ op_b.sign;
            prod_q.exponent <= op_zero ? '0 : exp_sum;
            prod_q.mantissa <= op_zero ? '0 : man_prod;
        end else if (dp_op == ALN) begin
            prod_q <= prod_aln;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q  <= '0;
            answer <= '0;
        end else begin
            answer <= '0;
            unique case (dp_op)
                ALN: acc_q <= acc_aln;
                ACC: begin
                    acc_q.sign     <= sum_sign;
                    acc_q.mantissa <= mag_sum;
                end
                NRM: acc_q <= acc_nrm;
                CLR: begin
                    acc_q  <= '0;
                    answer <= last_product ? packed_ans : float_sp'(ALL_ONES);
                end
                default: ;
            endcase
        end
    end

    // Leading one sits at the weight-one bit, or the sum is exactly zero
    a_norm_fits : assert property (
        @(posedge clk) disable iff (rst)
        (dp_op == NRM) |=> !acc_q.mantissa[ACC_MAN_W-1] &&
                           (acc_q.mantissa[LEAD_BIT] || (acc_q.mantissa == '0))
    ) else $error("accumulator not normalized after normalize");

endmodule

// ==== source/fma_sequencer.sv ====
/* One product in flight at a time. OUTPUT holds while either neighbor is
   busy; answer_ready and error are registered one-cycle pulses */
`timescale 1ns/1ps
`include "fma_params.svh"

module fma_sequencer
    import fma_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  both_valid,
    input  logic                  one_valid,
    input  logic                  in_error,
    input  logic                  right_busy,
    input  logic                  down_busy,
    input  logic [`FMA_CNT_W-1:0] dot_length,
    output logic                  capture_en,
    output logic                  forward_en,
    output logic                  busy,
    output logic                  answer_ready,
    output logic                  error,
    output dp_op_e                dp_op,
    output logic                  last_product
);

    cell_state_e           state;
    cell_state_e           next_state;
    logic [`FMA_CNT_W-1:0] prod_count;   // Products folded since the last answer

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb begin
        unique case (state)
            IDLE, LOAD: begin
                if (in_error)        next_state = ERROR;
                else if (both_valid) next_state = MULTIPLY;
                else if (one_valid)  next_state = LOAD;
                else                 next_state = IDLE;
            end
            MULTIPLY:   next_state = ALIGN;
            ALIGN:      next_state = ACCUMULATE;
            ACCUMULATE: next_state = NORMALIZE;
            NORMALIZE:  next_state = OUTPUT;
            OUTPUT: begin
                // Wait for both neighbors before dropping busy
                if (right_busy || down_busy) next_state = OUTPUT;
                else                         next_state = IDLE;
            end
            default:    next_state = IDLE;   // ERROR lasts one cycle
        endcase
    end

    assign capture_en   = (state == IDLE) || (state == LOAD);
    assign busy         = !capture_en;
    assign forward_en   = (state == OUTPUT);
    assign last_product = (state == OUTPUT) && (prod_count == dot_length);

    always_comb begin
        unique case (state)
            MULTIPLY:   dp_op = MUL;
            ALIGN:      dp_op = ALN;
            ACCUMULATE: dp_op = ACC;
            NORMALIZE:  dp_op = NRM;
            OUTPUT:     dp_op = last_product ? CLR : NOP;
            ERROR:      dp_op = CLR;
            default:    dp_op = NOP;
        endcase
    end

    // ----------------------------------------------------------
    // State, product count and status pulses
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            prod_count   <= '0;
            answer_ready <= 1'b0;
            error        <= 1'b0;
        end else begin
            state        <= next_state;
            answer_ready <= last_product;
            error        <= (state == ERROR);
            if ((state == ERROR) || last_product) begin
                prod_count <= '0;
            end else if (state == ACCUMULATE) begin
                prod_count <= prod_count + 1'b1;
            end
        end
    end

    a_ready_xor_error : assert property (
        @(posedge clk) disable iff (rst)
        !(answer_ready && error)
    ) else $error("answer_ready and error high together");

endmodule

// ==== source/fma_operand_capture.sv ====
/* Up operand becomes op_a, left becomes op_b; they may arrive in either order.
   A neighbor must not re-send a side that is already held */
`timescale 1ns/1ps

module fma_operand_capture
    import float_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    up_req,
    input  logic    left_req,
    input  float_sp up_operand,
    input  float_sp left_operand,
    input  logic    capture_en,
    input  logic    forward_en,
    output float_sp op_a,
    output float_sp op_b,
    output logic    both_valid,
    output logic    one_valid,
    output logic    in_error,
    output logic    right_req,
    output logic    down_req,
    output float_sp right_operand,
    output float_sp down_operand
);

    logic a_held;
    logic b_held;
    logic a_next;   // Held after this edge
    logic b_next;

    // Denormal, infinity or NaN
    function automatic logic bad_operand(input float_sp f);
        return (f.exponent == '1) || ((f.exponent == '0) && (f.mantissa != '0));
    endfunction

    assign a_next = a_held || (capture_en && up_req);
    assign b_next = b_held || (capture_en && left_req);

    assign in_error   = capture_en && ((up_req && bad_operand(up_operand)) ||
                                       (left_req && bad_operand(left_operand)));
    assign both_valid = capture_en && a_next && b_next;   // Pair completes on this edge
    assign one_valid  = capture_en && (a_next ^ b_next);

    // ----------------------------------------------------------
    // Arrival tracking
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            a_held <= 1'b0;
            b_held <= 1'b0;
        end else if (in_error || both_valid || !capture_en) begin
            a_held <= 1'b0;   // Pair handed on, or partial pair dropped
            b_held <= 1'b0;
        end else begin
            a_held <= a_next;
            b_held <= b_next;
        end
    end

    always_ff @(posedge clk) begin
        if (capture_en && up_req) op_a <= up_operand;
        if (capture_en && left_req) op_b <= left_operand;
    end

    // ----------------------------------------------------------
    // Forwarding, left flows right and up flows down
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            right_req <= 1'b0;
            down_req  <= 1'b0;
        end else begin
            right_req <= forward_en;
            down_req  <= forward_en;
        end
    end

    always_ff @(posedge clk) begin
        if (forward_en) begin
            right_operand <= op_b;
            down_operand  <= op_a;
        end
    end

    a_no_resend : assert property (
        @(posedge clk) disable iff (rst)
        capture_en && (a_held || b_held) |-> !(a_held && up_req) && !(b_held && left_req)
    ) else $error("request for an operand already held");

endmodule

// ==== source/fma_length_cfg.sv ====
/* Number of products folded into each answer.
   Write only while the cell is idle; zero is not a legal length */
`timescale 1ns/1ps
`include "fma_params.svh"

module fma_length_cfg (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cfg_we,
    input  logic [`FMA_CNT_W-1:0] cfg_length,
    output logic [`FMA_CNT_W-1:0] dot_length
);

    localparam int CNT_W = `FMA_CNT_W;

    // ----------------------------------------------------------
    // Length register
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            dot_length <= CNT_W'(`FMA_DEFAULT_LEN);
        end else if (cfg_we) begin
            dot_length <= cfg_length;
        end
    end

    // A zero length would never match the product count, so no answer
    // would ever be presented
    a_no_zero_length : assert property (
        @(posedge clk) disable iff (rst)
        cfg_we |-> (cfg_length != '0)
    ) else $error("length write of zero");

endmodule

// ==== source/fma_ctrl_pkg.sv ====
/* Cell sequencer states and the step opcodes it issues to the datapath */

package fma_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,        // One operand held, waiting for the other
        MULTIPLY,
        ALIGN,
        ACCUMULATE,
        NORMALIZE,
        OUTPUT,      // Forward pair, present answer on the last product
        ERROR
    } cell_state_e;

    typedef enum logic [2:0] {
        NOP,
        MUL,
        ALN,
        ACC,
        NRM,
        CLR          // Pack or flag the answer, then zero the sum
    } dp_op_e;

endpackage

// ==== source/float_pkg.sv ====
/* External single-precision word and the wider internal form used for
   the product and the running sum. The hidden bit lives in the mantissa */
`include "fma_params.svh"

package float_pkg;

    // Internal widths derived from the external format
    localparam int ACC_EXP_W = `FMA_EXP_W + 2;        // Signed, unbiased
    localparam int ACC_MAN_W = 2 * (`FMA_MAN_W + 1);  // Two integer bits

    // IEEE 754 single precision, as seen on cell ports
    typedef struct packed {
        logic                  sign;
        logic [`FMA_EXP_W-1:0] exponent;
        logic [`FMA_MAN_W-1:0] mantissa;
    } float_sp;

    // Product and accumulator
    // Weight-one bit sits at ACC_MAN_W-2
    typedef struct packed {
        logic                        sign;
        logic signed [ACC_EXP_W-1:0] exponent;
        logic [ACC_MAN_W-1:0]        mantissa;
    } acc_float;

endpackage

// ==== source/fma_params.svh ====
/* Field widths follow IEEE 754 single precision.
   FMA_CNT_W bounds the longest dot product the cell can count */
`ifndef FMA_PARAMS_SVH
`define FMA_PARAMS_SVH

// ----------------------------------------------------------
// Float format
// ----------------------------------------------------------
`define FMA_EXP_W       8
// Stored mantissa, hidden bit not included
`define FMA_MAN_W       23
`define FMA_FLOAT_W     32
`define FMA_EXP_BIAS    127

// ----------------------------------------------------------
// Sequencing
// ----------------------------------------------------------
// Product counter and length register
`define FMA_CNT_W       8
// Products per answer out of reset
`define FMA_DEFAULT_LEN 4

`endif
